// ==== common/rvc_cfg.svh ====
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// Queue entries, a power of two of 4 or more
`define FETCH_BUFFER_DEPTH 8

// Occupancy that raises fetchHold
// Leaves room for two entries of one word plus the entry in flight
`define FETCH_HOLD_LEVEL (`FETCH_BUFFER_DEPTH - 3)

`endif

// ==== common/rvc_pkg.sv ====
package rvc_pkg;

   typedef logic [31:0] instrT;
   typedef logic [15:0] compactInstrT;
   typedef logic [6:0] opcodeT;
   typedef logic [4:0] regIdxT;

   typedef struct packed {
      instrT instr;
      logic  isCompact; // Only instr[15:0] is valid when set
   } fetchEntryT;

   // RV32I major opcodes
   localparam opcodeT opcLoad = 7'b0000011;
   localparam opcodeT opcOpImm = 7'b0010011;
   localparam opcodeT opcLui = 7'b0110111;
   localparam opcodeT opcStore = 7'b0100011;
   localparam opcodeT opcOp = 7'b0110011;
   localparam opcodeT opcBranch = 7'b1100011;
   localparam opcodeT opcJalr = 7'b1100111;
   localparam opcodeT opcJal = 7'b1101111;
   localparam opcodeT opcSystem = 7'b1110011;

   // Implicit operands of the compressed forms
   localparam regIdxT regZero = 5'd0;
   localparam regIdxT regRa = 5'd1;
   localparam regIdxT regSp = 5'd2;

   // Low two bits 11 mark a 32-bit instruction
   function automatic logic isCompressed(compactInstrT half);
      return half[1:0] != 2'b11;
   endfunction

endpackage

// ==== verilog/FetchAligner.sv ====
`timescale 1ns/100ps

module FetchAligner
   import rvc_pkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       fetchStrobe,
   input  instrT      fetchWord,
   output logic       entryStrobe,
   output fetchEntryT entry,
   output logic       pendingSlot
);

   compactInstrT loHalf;
   compactInstrT hiHalf;

   compactInstrT leftHalf; // Upper half carried to the next cycle
   logic         leftValid;
   logic         leftIsWhole; // Whole compressed instr, else start of a 32-bit one

   logic         emitNext;
   fetchEntryT   entryNext;
   logic         leftValidNext;
   logic         leftIsWholeNext;
   compactInstrT leftHalfNext;

   assign loHalf = fetchWord[15:0];
   assign hiHalf = fetchWord[31:16];
   assign pendingSlot = leftValid & leftIsWhole;

   always_comb begin
      emitNext = 1'b0;
      entryNext = '{instr: fetchWord, isCompact: 1'b0};
      leftValidNext = leftValid;
      leftIsWholeNext = leftIsWhole;
      leftHalfNext = leftHalf;

      if (pendingSlot) begin
         // Second compressed half of the previous word, no new word taken
         emitNext = 1'b1;
         entryNext = '{instr: {16'h0000, leftHalf}, isCompact: 1'b1};
         leftValidNext = 1'b0;
      end else if (fetchStrobe) begin
         emitNext = 1'b1;
         if (leftValid || isCompressed(loHalf)) begin
            if (leftValid) begin
               entryNext = '{instr: {loHalf, leftHalf}, isCompact: 1'b0}; // Stitched
            end else begin
               entryNext = '{instr: {16'h0000, loHalf}, isCompact: 1'b1};
            end
            leftValidNext = 1'b1; // Upper half is always left over here
            leftIsWholeNext = isCompressed(hiHalf);
            leftHalfNext = hiHalf;
         end else begin
            leftValidNext = 1'b0; // Aligned 32-bit instr
         end
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         entryStrobe <= 1'b0;
         leftValid <= 1'b0;
         leftIsWhole <= 1'b0;
      end else begin
         entryStrobe <= emitNext;
         leftValid <= leftValidNext;
         leftIsWhole <= leftIsWholeNext;
      end
   end

   always_ff @(posedge clk) begin
      if (emitNext) begin
         entry <= entryNext;
      end
      leftHalf <= leftHalfNext;
   end

endmodule

// ==== verilog/InstructionBuffer.sv ====
`timescale 1ns/100ps
`include "rvc_cfg.svh"

module InstructionBuffer #(
   parameter type entryT = logic [31:0],
   parameter int  depth = `FETCH_BUFFER_DEPTH,
   parameter int  holdLevel = `FETCH_HOLD_LEVEL
) (
   input  logic  clk,
   input  logic  rstN,
   input  logic  pushStrobe,
   input  entryT pushEntry,
   input  logic  reserve,
   input  logic  hold,
   output logic  popStrobe,
   output entryT popEntry,
   output logic  almostFull
);

   localparam int ptrW = $clog2(depth);
   localparam logic [ptrW:0] holdCount = (ptrW + 1)'(holdLevel);

   entryT mem [depth];

   logic [ptrW-1:0] wrPtr;
   logic [ptrW-1:0] rdPtr;
   logic [ptrW:0]   count;
   logic            empty;

   assign empty = (count == '0);
   assign popStrobe = !empty && !hold;
   assign popEntry = mem[rdPtr]; // Head entry

   // A reserved slot also owns the next write cycle
   assign almostFull = reserve || (count >= holdCount);

   always_ff @(posedge clk) begin
      if (pushStrobe) begin
         mem[wrPtr] <= pushEntry;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (pushStrobe) begin
            wrPtr <= wrPtr + 1'b1; // Wraps at depth
         end
         if (popStrobe) begin
            rdPtr <= rdPtr + 1'b1;
         end
         case ({pushStrobe, popStrobe})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== expander/CompactInstructionsUnit.sv ====
`timescale 1ns/100ps

module CompactInstructionsUnit
   import rvc_pkg::*;
(
   input  logic       clk,
   input  logic       rstN,
   input  logic       inStrobe,
   input  fetchEntryT inEntry,
   output logic       outStrobe,
   output instrT      outInstr,
   output logic       isIllegal,
   output logic       isIgnored
);

   compactInstrT half;
   logic         isCompactIn;
   logic [2:0]   funct3;
   regIdxT       rdFull;
   regIdxT       rs2Full;
   regIdxT       rs1Short;
   regIdxT       rs2Short;
   logic [4:0]   shamt;

   logic [11:0]  immAddi4spn;
   logic [11:0]  immLw; // Shared by C.LW and C.SW
   logic [11:0]  immCi; // C.ADDI, C.LI, C.ANDI
   logic [20:0]  immJ;
   logic [11:0]  immAddi16sp;
   logic [19:0]  immLui;
   logic [12:0]  immB;
   logic [11:0]  immLwsp;
   logic [11:0]  immSwsp;

   instrT        expanded;
   logic         illegal;
   logic         ignored;

   assign half = inEntry.instr[15:0];
   assign isCompactIn = inEntry.isCompact && isCompressed(half);
   assign funct3 = half[15:13];
   assign rdFull = half[11:7];
   assign rs2Full = half[6:2];
   assign rs1Short = {2'b01, half[9:7]}; // x8..x15
   assign rs2Short = {2'b01, half[4:2]};
   assign shamt = half[6:2];

   assign immAddi4spn = {2'b00, half[10:7], half[12:11], half[5], half[6], 2'b00};
   assign immLw = {5'b00000, half[5], half[12:10], half[6], 2'b00};
   assign immCi = {{7{half[12]}}, half[6:2]};
   assign immJ = {{10{half[12]}}, half[8], half[10:9], half[6], half[7], half[2],
                  half[11], half[5:3], 1'b0};
   assign immAddi16sp = {{3{half[12]}}, half[4:3], half[5], half[2], half[6], 4'b0000};
   assign immLui = {{15{half[12]}}, half[6:2]};
   assign immB = {{5{half[12]}}, half[6:5], half[2], half[11:10], half[4:3], 1'b0};
   assign immLwsp = {4'b0000, half[3:2], half[12], half[6:4], 2'b00};
   assign immSwsp = {4'b0000, half[8:7], half[12:9], 2'b00};

   always_comb begin
      expanded = '0; // Stays zero for illegal and ignored forms
      illegal = 1'b0;
      ignored = 1'b0;

      if (!isCompactIn) begin
         expanded = inEntry.instr;
      end else begin
         case (half[1:0])
            2'b00: begin
               case (funct3)
                  3'b000: begin
                     if (half[12:5] == 8'h00) begin
                        illegal = 1'b1; // Includes the all-zero halfword
                     end else begin // C.ADDI4SPN
                        expanded = {immAddi4spn, regSp, 3'b000, rs2Short, opcOpImm};
                     end
                  end
                  3'b010:  expanded = {immLw, rs1Short, 3'b010, rs2Short, opcLoad};
                  3'b100:  illegal = 1'b1;
                  3'b110:  expanded = {immLw[11:5], rs2Short, rs1Short, 3'b010, immLw[4:0],
                                       opcStore};
                  default: ignored = 1'b1; // C.FLD C.FLW C.FSD C.FSW
               endcase
            end

            2'b01: begin
               case (funct3)
                  3'b000: expanded = {immCi, rdFull, 3'b000, rdFull, opcOpImm};
                  3'b001: expanded = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], regRa, opcJal};
                  3'b010: expanded = {immCi, regZero, 3'b000, rdFull, opcOpImm};
                  3'b011: begin
                     if ({half[12], half[6:2]} == 6'd0) begin
                        illegal = 1'b1;
                     end else if (rdFull == regSp) begin // C.ADDI16SP
                        expanded = {immAddi16sp, regSp, 3'b000, regSp, opcOpImm};
                     end else begin
                        expanded = {immLui, rdFull, opcLui};
                     end
                  end
                  3'b100: begin
                     case (half[11:10])
                        2'b00, 2'b01: begin
                           if (half[12]) begin
                              ignored = 1'b1; // shamt[5] only exists on RV64
                           end else begin // C.SRLI C.SRAI
                              expanded = {1'b0, half[10], 5'b00000, shamt, rs1Short, 3'b101,
                                          rs1Short, opcOpImm};
                           end
                        end
                        2'b10: expanded = {immCi, rs1Short, 3'b111, rs1Short, opcOpImm};
                        default: begin
                           case ({half[12], half[6:5]})
                              3'b000: expanded = {7'b0100000, rs2Short, rs1Short, 3'b000,
                                                  rs1Short, opcOp};
                              3'b001: expanded = {7'b0000000, rs2Short, rs1Short, 3'b100,
                                                  rs1Short, opcOp};
                              3'b010: expanded = {7'b0000000, rs2Short, rs1Short, 3'b110,
                                                  rs1Short, opcOp};
                              3'b011: expanded = {7'b0000000, rs2Short, rs1Short, 3'b111,
                                                  rs1Short, opcOp};
                              3'b100, 3'b101: ignored = 1'b1; // C.SUBW C.ADDW
                              default: illegal = 1'b1;
                           endcase
                        end
                     endcase
                  end
                  3'b101: expanded = {immJ[20], immJ[10:1], immJ[11], immJ[19:12], regZero,
                                      opcJal};
                  3'b110: expanded = {immB[12], immB[10:5], regZero, rs1Short, 3'b000,
                                      immB[4:1], immB[11], opcBranch};
                  default: expanded = {immB[12], immB[10:5], regZero, rs1Short, 3'b001,
                                       immB[4:1], immB[11], opcBranch};
               endcase
            end

            2'b10: begin
               case (funct3)
                  3'b000: begin
                     if (half[12]) begin
                        ignored = 1'b1;
                     end else begin // C.SLLI
                        expanded = {7'b0000000, shamt, rdFull, 3'b001, rdFull, opcOpImm};
                     end
                  end
                  3'b010: begin
                     if (rdFull == regZero) begin
                        illegal = 1'b1;
                     end else begin // C.LWSP
                        expanded = {immLwsp, regSp, 3'b010, rdFull, opcLoad};
                     end
                  end
                  3'b100: begin
                     if (rs2Full != regZero) begin // C.MV or C.ADD
                        expanded = {7'b0000000, rs2Full, half[12] ? rdFull : regZero, 3'b000,
                                    rdFull, opcOp};
                     end else if (rdFull != regZero) begin // C.JR or C.JALR
                        expanded = {12'h000, rdFull, 3'b000, half[12] ? regRa : regZero,
                                    opcJalr};
                     end else if (half[12]) begin
                        expanded = {12'h001, regZero, 3'b000, regZero, opcSystem}; // EBREAK
                     end else begin
                        illegal = 1'b1;
                     end
                  end
                  3'b110: expanded = {immSwsp[11:5], rs2Full, regSp, 3'b010, immSwsp[4:0],
                                      opcStore};
                  default: ignored = 1'b1; // FP stack loads and stores
               endcase
            end

            default: expanded = inEntry.instr;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outStrobe <= 1'b0;
         isIllegal <= 1'b0;
         isIgnored <= 1'b0;
      end else begin
         outStrobe <= inStrobe;
         if (inStrobe) begin
            isIllegal <= illegal;
            isIgnored <= ignored;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (inStrobe) begin
         outInstr <= expanded;
      end
   end

endmodule

// ==== verilog/FetchFrontEnd.sv ====
`timescale 1ns/100ps

module FetchFrontEnd
   import rvc_pkg::*;
(
   input  logic  clk,
   input  logic  rstN,
   input  logic  fetchStrobe,
   input  instrT fetchWord,
   input  logic  decodeHold,
   output logic  fetchHold,
   output logic  instrStrobe,
   output instrT instr,
   output logic  isIllegal,
   output logic  isIgnored
);

   logic       entryStrobe;
   fetchEntryT entry;
   logic       pendingSlot;
   logic       popStrobe;
   fetchEntryT popEntry;

   FetchAligner aligner (
      .clk         (clk),
      .rstN        (rstN),
      .fetchStrobe (fetchStrobe),
      .fetchWord   (fetchWord),
      .entryStrobe (entryStrobe),
      .entry       (entry),
      .pendingSlot (pendingSlot)
   );

   InstructionBuffer #(
      .entryT (fetchEntryT)
   ) instrBuffer (
      .clk        (clk),
      .rstN       (rstN),
      .pushStrobe (entryStrobe),
      .pushEntry  (entry),
      .reserve    (pendingSlot), // Second half still owed by the aligner
      .hold       (decodeHold),
      .popStrobe  (popStrobe),
      .popEntry   (popEntry),
      .almostFull (fetchHold)
   );

   CompactInstructionsUnit expander (
      .clk       (clk),
      .rstN      (rstN),
      .inStrobe  (popStrobe),
      .inEntry   (popEntry),
      .outStrobe (instrStrobe),
      .outInstr  (instr),
      .isIllegal (isIllegal),
      .isIgnored (isIgnored)
   );

endmodule

// ==== testbench/FetchChecker.sv ====
`timescale 1ns/100ps

module FetchChecker
   import rvc_pkg::*;
(
   input logic  clk,
   input logic  rstN,
   input logic  instrStrobe,
   input instrT instr,
   input logic  isIllegal,
   input logic  isIgnored
);

   logic [33:0] expQ[$]; // {instr, isIllegal, isIgnored} in program order
   int          testNum = 0;
   int          passCount = 0;
   int          errCount = 0;

   function automatic void expectOutput(input logic [33:0] e);
      expQ.push_back(e);
   endfunction

   function automatic int pendingCount();
      return expQ.size();
   endfunction

   // Outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      logic [33:0] want;
      if (rstN && instrStrobe) begin
         testNum++;
         if (expQ.size() == 0) begin
            $display("Test %0d failed: an instruction came out that no table row expects",
                     testNum);
            errCount++;
         end else begin
            want = expQ.pop_front();
            if ({instr, isIllegal, isIgnored} !== want) begin
               $display("ERR %0t: test %0d got %h ill %b ign %b, expected %h ill %b ign %b",
                        $time, testNum, instr, isIllegal, isIgnored,
                        want[33:2], want[1], want[0]);
               errCount++;
            end else begin
               $display("Test %0d ok: %h ill %b ign %b", testNum, instr, isIllegal, isIgnored);
               passCount++;
            end
         end
      end
   end

endmodule

// ==== testbench/FetchFrontEnd_assertions.sv ====
`timescale 1ns/100ps

module FetchFrontEnd_assertions (
   input logic clk,
   input logic rstN,
   input logic fetchStrobe,
   input logic fetchHold,
   input logic instrStrobe,
   input logic isIllegal,
   input logic isIgnored
);

   int assertFails = 0;

   noStrobeWhileHeld: assert property (@(posedge clk) disable iff (!rstN)
      fetchStrobe |-> !fetchHold)
      else begin
         $error("fetchStrobe while fetchHold is high");
         assertFails++;
      end

   quietInReset: assert property (@(posedge clk) !rstN |-> !instrStrobe)
      else begin
         $error("instrStrobe high during reset");
         assertFails++;
      end

   flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
      !(isIllegal && isIgnored))
      else begin
         $error("isIllegal and isIgnored both high");
         assertFails++;
      end

endmodule

bind FetchFrontEnd FetchFrontEnd_assertions asrt (
   .clk         (clk),
   .rstN        (rstN),
   .fetchStrobe (fetchStrobe),
   .fetchHold   (fetchHold),
   .instrStrobe (instrStrobe),
   .isIllegal   (isIllegal),
   .isIgnored   (isIgnored)
);

// ==== testbench/FetchFrontEndTb.sv ====
`timescale 1ns/100ps

module FetchFrontEndTb;

   typedef struct packed {
      logic [31:0] word;
      logic        holdOn; // Random decodeHold while this row is applied
      logic [1:0]  nExp;
      logic [33:0] exp0; // {instr, isIllegal, isIgnored}
      logic [33:0] exp1;
   } rowT;

   logic        clk;
   logic        rstN;
   logic        fetchStrobe;
   logic [31:0] fetchWord;
   logic        decodeHold;
   logic        fetchHold;
   logic        instrStrobe;
   logic [31:0] instr;
   logic        isIllegal;
   logic        isIgnored;

   rowT         rows[$];
   logic [31:0] lfsr = 32'hbb0f;
   int          cycleCount = 0;
   int          timeoutLimit = 1000000;

   FetchFrontEnd DUT (
      .clk         (clk),
      .rstN        (rstN),
      .fetchStrobe (fetchStrobe),
      .fetchWord   (fetchWord),
      .decodeHold  (decodeHold),
      .fetchHold   (fetchHold),
      .instrStrobe (instrStrobe),
      .instr       (instr),
      .isIllegal   (isIllegal),
      .isIgnored   (isIgnored)
   );

   FetchChecker outCheck (
      .clk         (clk),
      .rstN        (rstN),
      .instrStrobe (instrStrobe),
      .instr       (instr),
      .isIllegal   (isIllegal),
      .isIgnored   (isIgnored)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Galois LFSR, one step per bit
   function automatic logic holdBit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
         lfsr = lfsr ^ 32'hA300_0000;
      end
      return b;
   endfunction

   task automatic addRow(input logic [31:0] word, input logic holdOn, input logic [1:0] nExp,
                         input logic [33:0] exp0, input logic [33:0] exp1);
      rows.push_back({word, holdOn, nExp, exp0, exp1});
   endtask

   task automatic applyRow(input rowT r, input logic randomHold);
      decodeHold = (randomHold || r.holdOn) ? holdBit() : 1'b0;
      while (fetchHold) begin
         fetchStrobe = 1'b0;
         @(posedge clk);
         #10;
         decodeHold = (randomHold || r.holdOn) ? holdBit() : 1'b0;
      end
      fetchStrobe = 1'b1;
      fetchWord = r.word;
      if (r.nExp > 0) outCheck.expectOutput(r.exp0);
      if (r.nExp > 1) outCheck.expectOutput(r.exp1);
      @(posedge clk);
      #10;
      fetchStrobe = 1'b0;
   endtask

   task automatic buildTable();
      // Two compressed per word, low half first
      addRow(32'h4144_0040, 1'b0, 2, {32'h00410413, 2'b00}, {32'h00452483, 2'b00});
      addRow(32'h10FD_C504, 1'b0, 2, {32'h00952423, 2'b00}, {32'hFFF08093, 2'b00});
      addRow(32'h5281_2021, 1'b0, 2, {32'h008000EF, 2'b00}, {32'hFE000293, 2'b00});
      addRow(32'h71FD_6185, 1'b0, 2, {32'h000011B7, 2'b00}, {32'hFFFFF1B7, 2'b00});
      addRow(32'h800D_7139, 1'b0, 2, {32'hFC010113, 2'b00}, {32'h00345413, 2'b00});
      addRow(32'h9979_8485, 1'b0, 2, {32'h4014D493, 2'b00}, {32'hFFE57513, 2'b00});
      addRow(32'h8C65_8C05, 1'b0, 2, {32'h40940433, 2'b00}, {32'h00947433, 2'b00});
      addRow(32'h8D4D_8C25, 1'b0, 2, {32'h00944433, 2'b00}, {32'h00B56533, 2'b00});
      addRow(32'hC801_BFFD, 1'b0, 2, {32'hFFFFF06F, 2'b00}, {32'h00040863, 2'b00});
      addRow(32'h0292_FCF5, 1'b0, 2, {32'hFE049EE3, 2'b00}, {32'h00429293, 2'b00});
      addRow(32'hCA1E_4332, 1'b0, 2, {32'h00C12303, 2'b00}, {32'h00712A23, 2'b00});
      addRow(32'h952E_852E, 1'b0, 2, {32'h00B00533, 2'b00}, {32'h00B50533, 2'b00});
      addRow(32'h9282_8082, 1'b0, 2, {32'h00008067, 2'b00}, {32'h000280E7, 2'b00});
      addRow(32'h9002_0000, 1'b0, 2, {32'h00000000, 2'b10}, {32'h00100073, 2'b00});
      // Aligned 32-bit words
      addRow(32'h00A5_0533, 1'b0, 1, {32'h00A50533, 2'b00}, 34'h0);
      addRow(32'h1234_5037, 1'b0, 1, {32'h12345037, 2'b00}, 34'h0);
      // Reserved encodings
      addRow(32'h0004_8000, 1'b1, 2, {32'h00000000, 2'b10}, {32'h00000000, 2'b10});
      addRow(32'h4002_9C41, 1'b0, 2, {32'h00000000, 2'b10}, {32'h00000000, 2'b10});
      addRow(32'h8002_6181, 1'b0, 2, {32'h00000000, 2'b10}, {32'h00000000, 2'b10});
      // FP and RV64 forms
      addRow(32'hE000_2000, 1'b1, 2, {32'h00000000, 2'b01}, {32'h00000000, 2'b01});
      addRow(32'h9C01_2002, 1'b0, 2, {32'h00000000, 2'b01}, {32'h00000000, 2'b01});
      addRow(32'h900D_1292, 1'b0, 2, {32'h00000000, 2'b01}, {32'h00000000, 2'b01});
      // Straddling 32-bit instructions
      addRow(32'h0533_4144, 1'b1, 1, {32'h00452483, 2'b00}, 34'h0);
      addRow(32'h0292_00B5, 1'b1, 2, {32'h00B50533, 2'b00}, {32'h00429293, 2'b00});
      addRow(32'h0413_0040, 1'b0, 1, {32'h00410413, 2'b00}, 34'h0);
      addRow(32'h0093_0041, 1'b1, 1, {32'h00410413, 2'b00}, 34'h0);
      addRow(32'h852E_0000, 1'b0, 2, {32'h00000093, 2'b00}, {32'h00B00533, 2'b00});
   endtask

   initial begin
      while (cycleCount < timeoutLimit) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Timeout after %0d cycles with %0d outputs still missing", cycleCount,
               outCheck.pendingCount());
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int total;
      total = 0;
      rstN = 1'b0;
      fetchStrobe = 1'b0;
      fetchWord = '0;
      decodeHold = 1'b0;
      buildTable();
      foreach (rows[i]) total += rows[i].nExp;
      total = total * 2;
      timeoutLimit = 2 * rows.size() * 8 + 50;
      repeat (4) @(posedge clk);
      #10;
      rstN = 1'b1;
      for (int pass = 0; pass < 2; pass++) begin
         foreach (rows[i]) applyRow(rows[i], pass == 1); // Second pass under random hold
      end
      decodeHold = 1'b0;
      while (outCheck.pendingCount() != 0) @(posedge clk);
      repeat (5) @(posedge clk);
      $display("Outputs expected %0d, passed %0d, errors %0d, assertion failures %0d",
               total, outCheck.passCount, outCheck.errCount, DUT.asrt.assertFails);
      if (outCheck.errCount == 0 && outCheck.passCount == total && DUT.asrt.assertFails == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+common
common/rvc_pkg.sv
verilog/FetchAligner.sv
verilog/InstructionBuffer.sv
expander/CompactInstructionsUnit.sv
verilog/FetchFrontEnd.sv
testbench/FetchChecker.sv
testbench/FetchFrontEnd_assertions.sv
testbench/FetchFrontEndTb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - common
    files:
      - common/rvc_pkg.sv
      - verilog/FetchAligner.sv
      - verilog/InstructionBuffer.sv
      - expander/CompactInstructionsUnit.sv
      - verilog/FetchFrontEnd.sv
  - target: test
    files:
      - testbench/FetchChecker.sv
      - testbench/FetchFrontEnd_assertions.sv
      - testbench/FetchFrontEndTb.sv
